/* design/axil_slave.sv */
/*
 * AXI4-Lite slave front end. Handles the channel handshakes, latches
 * addresses and turns bus transfers into single-cycle register accesses.
 */

`timescale 1ns/100ps

module axil_slave
    import mac_regs_pkg::*;
(
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,

    // Write address and data channels
    input  logic [ADDR_W-1:0] S_AXI_AWADDR,
    input  logic              S_AXI_AWVALID,
    output logic              S_AXI_AWREADY,
    input  logic [DATA_W-1:0] S_AXI_WDATA,
    input  logic [STRB_W-1:0] S_AXI_WSTRB,
    input  logic              S_AXI_WVALID,
    output logic              S_AXI_WREADY,

    // Write response channel
    output logic [1:0]        S_AXI_BRESP,
    output logic              S_AXI_BVALID,
    input  logic              S_AXI_BREADY,

    // Read address and data channels
    input  logic [ADDR_W-1:0] S_AXI_ARADDR,
    input  logic              S_AXI_ARVALID,
    output logic              S_AXI_ARREADY,
    output logic [DATA_W-1:0] S_AXI_RDATA,
    output logic [1:0]        S_AXI_RRESP,
    output logic              S_AXI_RVALID,
    input  logic              S_AXI_RREADY,

    reg_access_if.axil_slave  access
);

    logic [ADDR_W-1:0] awaddr_q;
    logic [ADDR_W-1:0] araddr_q;
    logic              aw_accept;
    logic              ar_accept;

    ////////////////////
    // Write channel
    ////////////////////

    // Address and data must both be present
    assign aw_accept = ~S_AXI_AWREADY & S_AXI_AWVALID & S_AXI_WVALID;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
        end else begin
            // One-cycle ready pulse on both channels
            S_AXI_AWREADY <= aw_accept;
            S_AXI_WREADY  <= aw_accept;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_accept) begin
            awaddr_q <= S_AXI_AWADDR ^ BASE_ADDR;
        end
    end

    assign access.wr_en   = S_AXI_AWREADY & S_AXI_WREADY & S_AXI_AWVALID & S_AXI_WVALID;
    assign access.wr_addr = awaddr_q;
    assign access.wr_data = S_AXI_WDATA;
    assign access.wr_strb = S_AXI_WSTRB;

    // Response holds until the master takes it
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_BVALID <= 1'b0;
            S_AXI_BRESP  <= RESP_OKAY;
        end else if (access.wr_en && !S_AXI_BVALID) begin
            S_AXI_BVALID <= 1'b1;
            S_AXI_BRESP  <= RESP_OKAY;
        end else if (S_AXI_BVALID && S_AXI_BREADY) begin
            S_AXI_BVALID <= 1'b0;
        end
    end

    ////////////////////
    // Read channel
    ////////////////////

    assign ar_accept = ~S_AXI_ARREADY & S_AXI_ARVALID;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_ARREADY <= 1'b0;
        end else begin
            S_AXI_ARREADY <= ar_accept;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_accept) begin
            araddr_q <= S_AXI_ARADDR ^ BASE_ADDR;
        end
    end

    // No new read while a previous one is still waiting on RREADY
    assign access.rd_en   = S_AXI_ARREADY & S_AXI_ARVALID & ~S_AXI_RVALID;
    assign access.rd_addr = araddr_q;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_RVALID <= 1'b0;
            S_AXI_RRESP  <= RESP_OKAY;
        end else if (access.rd_en) begin
            S_AXI_RVALID <= 1'b1;
            S_AXI_RRESP  <= RESP_OKAY;
        end else if (S_AXI_RVALID && S_AXI_RREADY) begin
            S_AXI_RVALID <= 1'b0;
        end
    end

    // Sampled once per read, then held with RVALID
    always_ff @(posedge S_AXI_ACLK) begin
        if (access.rd_en) begin
            S_AXI_RDATA <= access.rd_data;
        end
    end

endmodule

/* design/mac_attach_regs.sv */
/*
 * Top level of the MAC attachment register block. Plain AXI4-Lite ports
 * on one side, control words and packet counters on the other.
 */

`timescale 1ns/100ps

module mac_attach_regs
    import mac_regs_pkg::*;
(
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,

    // AXI4-Lite
    input  logic [ADDR_W-1:0]       S_AXI_AWADDR,
    input  logic                    S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,
    input  logic [DATA_W-1:0]       S_AXI_WDATA,
    input  logic [STRB_W-1:0]       S_AXI_WSTRB,
    input  logic                    S_AXI_WVALID,
    output logic                    S_AXI_WREADY,
    output logic [1:0]              S_AXI_BRESP,
    output logic                    S_AXI_BVALID,
    input  logic                    S_AXI_BREADY,
    input  logic [ADDR_W-1:0]       S_AXI_ARADDR,
    input  logic                    S_AXI_ARVALID,
    output logic                    S_AXI_ARREADY,
    output logic [DATA_W-1:0]       S_AXI_RDATA,
    output logic [1:0]              S_AXI_RRESP,
    output logic                    S_AXI_RVALID,
    input  logic                    S_AXI_RREADY,

    // Register side
    input  logic [DATA_W-1:0]       id_value,
    input  logic [DATA_W-1:0]       version_value,
    input  logic [DATA_W-1:0]       flip_in,
    input  logic [DATA_W-1:0]       debug_in,
    input  logic [DATA_W-1:0]       rx_mac_count,
    input  logic [DATA_W-1:0]       rx_queue_count,
    input  logic [DATA_W-1:0]       rx_conv_count,
    input  logic [DATA_W-1:0]       tx_mac_count,
    input  logic [DATA_W-1:0]       tx_queue_count,
    input  logic [DATA_W-1:0]       tx_conv_count,
    output logic [DATA_W-1:0]       reset_pulse,
    output logic [DATA_W-1:0]       flip_out,
    output logic [DATA_W-1:0]       debug_out,
    output logic [NUM_COUNTERS-1:0] counter_clear
);

    reg_access_if u_access ();

    axil_slave u_axil_slave (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .access        (u_access.axil_slave)
    );

    reg_file u_reg_file (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .access         (u_access.reg_file),
        .id_value       (id_value),
        .version_value  (version_value),
        .flip_in        (flip_in),
        .debug_in       (debug_in),
        .rx_mac_count   (rx_mac_count),
        .rx_queue_count (rx_queue_count),
        .rx_conv_count  (rx_conv_count),
        .tx_mac_count   (tx_mac_count),
        .tx_queue_count (tx_queue_count),
        .tx_conv_count  (tx_conv_count),
        .reset_pulse    (reset_pulse),
        .flip_out       (flip_out),
        .debug_out      (debug_out),
        .counter_clear  (counter_clear)
    );

endmodule

/* design/mac_regs_pkg.sv */
/*
 * Shared register map and constants for the MAC attachment register block.
 * Imported by the interface, the RTL modules and the testbench.
 */

package mac_regs_pkg;

    ////////////////////
    // Bus geometry
    ////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Incoming addresses are XORed with this
    localparam logic [ADDR_W-1:0] BASE_ADDR = 32'h0000_0000;

    ////////////////////
    // Register offsets
    ////////////////////

    localparam logic [ADDR_W-1:0] REG_ID_ADDR        = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] REG_VERSION_ADDR   = 32'h0000_0004;
    localparam logic [ADDR_W-1:0] REG_RESET_ADDR     = 32'h0000_0008;
    localparam logic [ADDR_W-1:0] REG_FLIP_ADDR      = 32'h0000_000C;
    localparam logic [ADDR_W-1:0] REG_DEBUG_ADDR     = 32'h0000_0010;
    localparam logic [ADDR_W-1:0] REG_RXMACPKT_ADDR  = 32'h0000_0014;
    localparam logic [ADDR_W-1:0] REG_RXQPKT_ADDR    = 32'h0000_0018;
    localparam logic [ADDR_W-1:0] REG_RXCONVPKT_ADDR = 32'h0000_001C;
    localparam logic [ADDR_W-1:0] REG_TXMACPKT_ADDR  = 32'h0000_0020;
    localparam logic [ADDR_W-1:0] REG_TXQPKT_ADDR    = 32'h0000_0024;
    localparam logic [ADDR_W-1:0] REG_TXCONVPKT_ADDR = 32'h0000_0028;

    // Defaults and idle values
    localparam logic [DATA_W-1:0] REG_RESET_DEFAULT = '0;
    localparam logic [DATA_W-1:0] REG_FLIP_DEFAULT  = '0;
    localparam logic [DATA_W-1:0] REG_DEBUG_DEFAULT = '0;

    // Returned for the write-only reset word and any unlisted offset
    localparam logic [DATA_W-1:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    ////////////////////
    // Packet counters
    ////////////////////

    localparam int NUM_COUNTERS = 6;

    typedef enum logic [2:0] {
        CNT_RX_MAC   = 3'd0,
        CNT_RX_QUEUE = 3'd1,
        CNT_RX_CONV  = 3'd2,
        CNT_TX_MAC   = 3'd3,
        CNT_TX_QUEUE = 3'd4,
        CNT_TX_CONV  = 3'd5
    } counter_e;

    // Offset of each counter, in counter_e order
    localparam logic [ADDR_W-1:0] COUNTER_ADDR [NUM_COUNTERS] = '{
        REG_RXMACPKT_ADDR,
        REG_RXQPKT_ADDR,
        REG_RXCONVPKT_ADDR,
        REG_TXMACPKT_ADDR,
        REG_TXQPKT_ADDR,
        REG_TXCONVPKT_ADDR
    };

endpackage

/* design/reg_access_if.sv */
/*
 * Decoded register accesses from the AXI4-Lite slave to the register file.
 * Strobes are single cycle; read data is the combinational mux output.
 */

`timescale 1ns/100ps

interface reg_access_if
    import mac_regs_pkg::*;
();

    // Write side
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;

    // Read side
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;

    modport axil_slave (
        output wr_en, wr_addr, wr_data, wr_strb,
        output rd_en, rd_addr,
        input  rd_data
    );

    modport reg_file (
        input  wr_en, wr_addr, wr_data, wr_strb,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

/* design/reg_file.sv */
/*
 * Register file behind the AXI4-Lite slave. Holds the flip and debug
 * control words and the soft-reset pulse, muxes read data and raises
 * clear-on-read pulses toward the packet counters.
 */

`timescale 1ns/100ps

module reg_file
    import mac_regs_pkg::*;
(
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,

    reg_access_if.reg_file          access,

    // Core-side words
    input  logic [DATA_W-1:0]       id_value,
    input  logic [DATA_W-1:0]       version_value,
    input  logic [DATA_W-1:0]       flip_in,
    input  logic [DATA_W-1:0]       debug_in,

    // Packet counters
    input  logic [DATA_W-1:0]       rx_mac_count,
    input  logic [DATA_W-1:0]       rx_queue_count,
    input  logic [DATA_W-1:0]       rx_conv_count,
    input  logic [DATA_W-1:0]       tx_mac_count,
    input  logic [DATA_W-1:0]       tx_queue_count,
    input  logic [DATA_W-1:0]       tx_conv_count,

    output logic [DATA_W-1:0]       reset_pulse,
    output logic [DATA_W-1:0]       flip_out,
    output logic [DATA_W-1:0]       debug_out,
    output logic [NUM_COUNTERS-1:0] counter_clear
);

    logic [DATA_W-1:0]       count_word [NUM_COUNTERS];
    logic [NUM_COUNTERS-1:0] counter_hit;

    // Replace only the bytes whose strobe is set
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            flip_out  <= REG_FLIP_DEFAULT;
            debug_out <= REG_DEBUG_DEFAULT;
        end else if (access.wr_en) begin
            case (access.wr_addr)
                REG_FLIP_ADDR: begin
                    flip_out <= merge_bytes(flip_out, access.wr_data, access.wr_strb);
                end
                REG_DEBUG_ADDR: begin
                    debug_out <= merge_bytes(debug_out, access.wr_data, access.wr_strb);
                end
                default: begin
                end
            endcase
        end
    end

    // Soft reset lasts one cycle, falls back to default otherwise
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            reset_pulse <= REG_RESET_DEFAULT;
        end else if (access.wr_en && access.wr_addr == REG_RESET_ADDR) begin
            reset_pulse <= merge_bytes(REG_RESET_DEFAULT, access.wr_data, access.wr_strb);
        end else begin
            reset_pulse <= REG_RESET_DEFAULT;
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    assign count_word[CNT_RX_MAC]   = rx_mac_count;
    assign count_word[CNT_RX_QUEUE] = rx_queue_count;
    assign count_word[CNT_RX_CONV]  = rx_conv_count;
    assign count_word[CNT_TX_MAC]   = tx_mac_count;
    assign count_word[CNT_TX_QUEUE] = tx_queue_count;
    assign count_word[CNT_TX_CONV]  = tx_conv_count;

    // One-hot match of rd_addr against the counter offsets
    always_comb begin
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            counter_hit[i] = (access.rd_addr == COUNTER_ADDR[i]);
        end
    end

    always_comb begin
        access.rd_data = UNMAPPED_DATA;
        case (access.rd_addr)
            REG_ID_ADDR:      access.rd_data = id_value;
            REG_VERSION_ADDR: access.rd_data = version_value;
            REG_FLIP_ADDR:    access.rd_data = flip_in;
            REG_DEBUG_ADDR:   access.rd_data = debug_in;
            default: begin
                for (int i = 0; i < NUM_COUNTERS; i++) begin
                    if (counter_hit[i]) begin
                        access.rd_data = count_word[i];
                    end
                end
            end
        endcase
    end

    // Clear pulse lines up with RVALID rising
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            counter_clear <= '0;
        end else if (access.rd_en) begin
            counter_clear <= counter_hit;
        end else begin
            counter_clear <= '0;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -f src.f --top-module tb_mac_attach_regs > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_mac_attach_regs > sim.log 2>&1

# The log decides the result
grep -q "TEST FAIL" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* src.f */
design/mac_regs_pkg.sv
design/reg_access_if.sv
design/axil_slave.sv
design/reg_file.sv
design/mac_attach_regs.sv
verification/tb_clock_gen.sv
verification/tb_mac_attach_regs.sv

/* verification/mac_regs_vectors.txt */
// Columns (hex): op, offset, data, strobes, expected value
// op 0 write, 1 read fixed, 2 read counter (data = index), 3 id, 4 version, 5 held read, FF end
00000001 0000000C 00000000 00000000 FFFFFFFF
00000001 00000010 00000000 00000000 00000000
00000000 0000000C A1B2C3D4 00000005 00B200D4
00000001 0000000C 00000000 00000000 FF4DFF2B
00000000 0000000C 11223344 00000008 11B200D4
00000001 0000000C 00000000 00000000 EE4DFF2B
00000000 00000010 CAFEF00D 00000003 0000F00D
00000000 00000010 12345678 00000004 0034F00D
00000001 00000010 00000000 00000000 0034F00D
00000000 00000008 A5A5A5A5 0000000F A5A5A5A5
00000000 00000008 0000FF99 00000002 0000FF00
00000000 00000008 12345678 00000000 00000000
00000002 00000014 00000000 00000000 00000000
00000002 00000018 00000001 00000000 00000000
00000002 0000001C 00000002 00000000 00000000
00000002 00000020 00000003 00000000 00000000
00000002 00000024 00000004 00000000 00000000
00000002 00000028 00000005 00000000 00000000
00000003 00000000 00000000 00000000 00000000
00000004 00000004 00000000 00000000 00000000
00000001 00000008 00000000 00000000 DEADBEEF
00000001 0000002C 00000000 00000000 DEADBEEF
00000001 000000FC 00000000 00000000 DEADBEEF
00000001 00000100 00000000 00000000 DEADBEEF
00000005 00000018 00000001 00000000 00000000
00000005 00000028 00000005 00000000 00000000
00000002 00000014 00000000 00000000 00000000
00000001 0000000C 00000000 00000000 EE4DFF2B
000000FF 00000000 00000000 00000000 00000000

/* verification/tb_clock_gen.sv */
/*
 * Testbench clock and reset source. 40 ns clock, active-low synchronous
 * reset held for the first 10 cycles and released on a falling edge.
 */

`timescale 1ns/100ps

module tb_clock_gen (
    output logic S_AXI_ACLK,
    output logic S_AXI_ARESETN
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #(HALF_PERIOD) S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        S_AXI_ARESETN = 1'b0;
        repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
    end

endmodule

/* verification/tb_mac_attach_regs.sv */
/*
 * Testbench for the MAC attachment register block. Replays the bus
 * operations in the vector file, drives random counter words and checks
 * read data, control outputs and clear-on-read pulses.
 */

`timescale 1ns/100ps

module tb_mac_attach_regs
    import mac_regs_pkg::*;
();

    localparam string       VECTOR_FILE       = "verification/mac_regs_vectors.txt";
    localparam int          MAX_VECTORS       = 64;
    localparam int          VEC_COLS          = 5;
    localparam int          CYCLES_PER_VECTOR = 40;
    localparam int          TIMEOUT_MARGIN    = 100;
    localparam int          HOLD_CYCLES       = 4;
    localparam logic [31:0] RANDOM_SEED       = 32'h3960_5ca0;

    // Operation codes in the first column
    localparam logic [31:0] OP_WRITE        = 32'h00;
    localparam logic [31:0] OP_READ         = 32'h01;
    localparam logic [31:0] OP_READ_COUNTER = 32'h02;
    localparam logic [31:0] OP_READ_ID      = 32'h03;
    localparam logic [31:0] OP_READ_VERSION = 32'h04;
    localparam logic [31:0] OP_READ_HELD    = 32'h05;
    localparam logic [31:0] OP_END          = 32'hFF;

    logic                    S_AXI_ACLK;
    logic                    S_AXI_ARESETN;
    logic [ADDR_W-1:0]       S_AXI_AWADDR;
    logic                    S_AXI_AWVALID;
    logic                    S_AXI_AWREADY;
    logic [DATA_W-1:0]       S_AXI_WDATA;
    logic [STRB_W-1:0]       S_AXI_WSTRB;
    logic                    S_AXI_WVALID;
    logic                    S_AXI_WREADY;
    logic [1:0]              S_AXI_BRESP;
    logic                    S_AXI_BVALID;
    logic                    S_AXI_BREADY;
    logic [ADDR_W-1:0]       S_AXI_ARADDR;
    logic                    S_AXI_ARVALID;
    logic                    S_AXI_ARREADY;
    logic [DATA_W-1:0]       S_AXI_RDATA;
    logic [1:0]              S_AXI_RRESP;
    logic                    S_AXI_RVALID;
    logic                    S_AXI_RREADY;
    logic [DATA_W-1:0]       id_word;
    logic [DATA_W-1:0]       version_word;
    logic [DATA_W-1:0]       flip_in;
    logic [DATA_W-1:0]       debug_in;
    logic [DATA_W-1:0]       count_words [NUM_COUNTERS];
    logic [DATA_W-1:0]       reset_pulse;
    logic [DATA_W-1:0]       flip_out;
    logic [DATA_W-1:0]       debug_out;
    logic [NUM_COUNTERS-1:0] counter_clear;

    logic [31:0] vec_mem [MAX_VECTORS*VEC_COLS];
    int          num_vectors;
    int          cycle_count   = 0;
    int          timeout_limit = TIMEOUT_MARGIN;

    tb_clock_gen u_clock_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN)
    );

    mac_attach_regs u_mac_attach_regs (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .S_AXI_AWADDR   (S_AXI_AWADDR),
        .S_AXI_AWVALID  (S_AXI_AWVALID),
        .S_AXI_AWREADY  (S_AXI_AWREADY),
        .S_AXI_WDATA    (S_AXI_WDATA),
        .S_AXI_WSTRB    (S_AXI_WSTRB),
        .S_AXI_WVALID   (S_AXI_WVALID),
        .S_AXI_WREADY   (S_AXI_WREADY),
        .S_AXI_BRESP    (S_AXI_BRESP),
        .S_AXI_BVALID   (S_AXI_BVALID),
        .S_AXI_BREADY   (S_AXI_BREADY),
        .S_AXI_ARADDR   (S_AXI_ARADDR),
        .S_AXI_ARVALID  (S_AXI_ARVALID),
        .S_AXI_ARREADY  (S_AXI_ARREADY),
        .S_AXI_RDATA    (S_AXI_RDATA),
        .S_AXI_RRESP    (S_AXI_RRESP),
        .S_AXI_RVALID   (S_AXI_RVALID),
        .S_AXI_RREADY   (S_AXI_RREADY),
        .id_value       (id_word),
        .version_value  (version_word),
        .flip_in        (flip_in),
        .debug_in       (debug_in),
        .rx_mac_count   (count_words[CNT_RX_MAC]),
        .rx_queue_count (count_words[CNT_RX_QUEUE]),
        .rx_conv_count  (count_words[CNT_RX_CONV]),
        .tx_mac_count   (count_words[CNT_TX_MAC]),
        .tx_queue_count (count_words[CNT_TX_QUEUE]),
        .tx_conv_count  (count_words[CNT_TX_CONV]),
        .reset_pulse    (reset_pulse),
        .flip_out       (flip_out),
        .debug_out      (debug_out),
        .counter_clear  (counter_clear)
    );

    ////////////////////
    // Core model
    ////////////////////

    // The core inverts flip and echoes debug, updated on falling edges
    initial begin
        flip_in  = ~REG_FLIP_DEFAULT;
        debug_in = REG_DEBUG_DEFAULT;
        forever begin
            @(negedge S_AXI_ACLK);
            flip_in  = ~flip_out;
            debug_in = debug_out;
        end
    end

    always @(posedge S_AXI_ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
            $display("TEST FAIL");
            $fatal(1, "Run timed out");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic draw_counters();
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            count_words[i] = $urandom();
        end
    endtask

    task automatic load_vectors();
        // Sentinel so that a short or missing file ends the list
        for (int i = 0; i < MAX_VECTORS * VEC_COLS; i++) begin
            vec_mem[i] = OP_END;
        end
        $readmemh(VECTOR_FILE, vec_mem);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && vec_mem[num_vectors * VEC_COLS] != OP_END) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            $display("No bus operations could be read from %s", VECTOR_FILE);
            $display("TEST FAIL");
            $fatal(1, "Empty vector file");
        end
        timeout_limit = num_vectors * CYCLES_PER_VECTOR + TIMEOUT_MARGIN;
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, input logic [DATA_W-1:0] expected);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = strb;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        @(negedge S_AXI_ACLK);
        while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
        check_value(32'(S_AXI_WREADY), 32'd1, "WREADY with AWREADY");
        @(negedge S_AXI_ACLK);
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        check_value(32'(S_AXI_AWREADY), 32'd0, "AWREADY one cycle later");
        check_value(32'(S_AXI_BVALID), 32'd1, "BVALID");
        check_value(32'(S_AXI_BRESP), 32'(RESP_OKAY), "BRESP");
        check_value(32'(counter_clear), 32'd0, "counter_clear during write");
        if (addr == REG_RESET_ADDR) begin
            check_value(reset_pulse, expected, "reset_pulse as BVALID rises");
        end else begin
            check_value(reset_pulse, REG_RESET_DEFAULT, "reset_pulse idle");
        end
        if (addr == REG_FLIP_ADDR) begin
            check_value(flip_out, expected, "flip_out after write");
        end
        if (addr == REG_DEBUG_ADDR) begin
            check_value(debug_out, expected, "debug_out after write");
        end
        @(negedge S_AXI_ACLK);
        check_value(32'(S_AXI_BVALID), 32'd0, "BVALID after BREADY");
        check_value(reset_pulse, REG_RESET_DEFAULT, "reset_pulse one cycle later");
    endtask

    // hold_cycles > 0 keeps RREADY low that long after RVALID rises
    task automatic do_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected,
                           input logic [NUM_COUNTERS-1:0] expected_clear, input int hold_cycles);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        S_AXI_RREADY  = (hold_cycles == 0);
        @(negedge S_AXI_ACLK);
        while (!S_AXI_ARREADY) @(negedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        S_AXI_ARVALID = 1'b0;
        check_value(32'(S_AXI_ARREADY), 32'd0, "ARREADY one cycle later");
        check_value(32'(S_AXI_RVALID), 32'd1, "RVALID");
        check_value(32'(S_AXI_RRESP), 32'(RESP_OKAY), "RRESP");
        check_value(S_AXI_RDATA, expected, "RDATA");
        check_value(32'(counter_clear), 32'(expected_clear), "counter_clear as RVALID rises");
        for (int i = 0; i < hold_cycles; i++) begin
            // New counter words must not reach the held RDATA
            draw_counters();
            @(negedge S_AXI_ACLK);
            check_value(32'(S_AXI_RVALID), 32'd1, "RVALID while RREADY low");
            check_value(S_AXI_RDATA, expected, "RDATA while RREADY low");
            check_value(32'(counter_clear), 32'd0, "counter_clear while RREADY low");
        end
        S_AXI_RREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        check_value(32'(S_AXI_RVALID), 32'd0, "RVALID after RREADY");
        check_value(32'(counter_clear), 32'd0, "counter_clear one cycle later");
    endtask

    task automatic run_vector(input int n);
        logic [31:0]             op;
        logic [31:0]             addr;
        logic [31:0]             data;
        logic [31:0]             strb;
        logic [31:0]             expected;
        counter_e                cnt;
        logic [NUM_COUNTERS-1:0] onehot;
        op       = vec_mem[n * VEC_COLS];
        addr     = vec_mem[n * VEC_COLS + 1];
        data     = vec_mem[n * VEC_COLS + 2];
        strb     = vec_mem[n * VEC_COLS + 3];
        expected = vec_mem[n * VEC_COLS + 4];
        if (op != OP_WRITE) begin
            draw_counters();
        end
        case (op)
            OP_WRITE:        do_write(addr, data, strb[STRB_W-1:0], expected);
            OP_READ:         do_read(addr, expected, '0, 0);
            OP_READ_ID:      do_read(addr, id_word, '0, 0);
            OP_READ_VERSION: do_read(addr, version_word, '0, 0);
            OP_READ_COUNTER, OP_READ_HELD: begin
                cnt         = counter_e'(data[2:0]);
                onehot      = '0;
                onehot[cnt] = 1'b1;
                do_read(addr, count_words[cnt], onehot, (op == OP_READ_HELD) ? HOLD_CYCLES : 0);
            end
            default: begin
                $display("Vector line %0d has an unknown operation code %h", n, op);
                $display("TEST FAIL");
                $fatal(1, "Bad vector");
            end
        endcase
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b1;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b1;
        void'($urandom(RANDOM_SEED));
        id_word      = $urandom();
        version_word = $urandom();
        draw_counters();
        load_vectors();

        @(posedge S_AXI_ARESETN);
        @(negedge S_AXI_ACLK);
        check_value(flip_out, REG_FLIP_DEFAULT, "flip_out after reset");
        check_value(debug_out, REG_DEBUG_DEFAULT, "debug_out after reset");
        check_value(reset_pulse, REG_RESET_DEFAULT, "reset_pulse after reset");
        check_value(32'(counter_clear), 32'd0, "counter_clear after reset");
        check_value(32'(S_AXI_BVALID), 32'd0, "BVALID after reset");
        check_value(32'(S_AXI_RVALID), 32'd0, "RVALID after reset");

        for (int n = 0; n < num_vectors; n++) begin
            run_vector(n);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
